// ==== fpu.f ====
hw/fpu_pkg.sv
hw/fpu_ctrl_if.sv
hw/fpu_sequencer.sv
hw/fpu_operand_align.sv
hw/fpu_mantissa_alu.sv
hw/fpu_normalize_round.sv
hw/fpu_top.sv
verification/fpu_sva.sv
verification/fpu_tb.sv

// ==== hw/fpu_ctrl_if.sv ====
`timescale 1ns/1ns

interface fpu_ctrl_if;
    import fpu_pkg::*;

    // sequencer to datapath
    logic       load;        // capture a, b and op
    logic       swap;        // b is the larger operand
    logic       alu_start;
    logic       first_pass;  // take the fresh alu result, not the loop register
    norm_e      norm_cmd;
    logic       norm_en;     // update the loop registers

    // datapath to sequencer
    logic       exp_neg;     // exponent difference a - b is negative
    logic       exp_zero;
    logic       mag_lt;      // fraction of b larger than fraction of a
    logic       alu_done;
    logic [2:0] alu_top;
    logic [2:0] loop_top;
    logic       loop_zero;

    modport sequencer (
        output load, swap, alu_start, first_pass, norm_cmd, norm_en,
        input  exp_neg, exp_zero, mag_lt, alu_done, alu_top, loop_top, loop_zero
    );

    modport datapath (
        input  load, swap, alu_start, first_pass, norm_cmd, norm_en,
        output exp_neg, exp_zero, mag_lt, alu_done, alu_top, loop_top, loop_zero
    );

endinterface

// ==== hw/fpu_mantissa_alu.sv ====
`timescale 1ns/1ns

module fpu_mantissa_alu (
    input  logic           clk,
    input  logic           reset,
    input  fpu_pkg::mant_t big_mant,
    input  fpu_pkg::mant_t small_mant,
    input  logic           sign_a,
    input  logic           sign_b,
    input  fpu_pkg::op_e   op_sel,
    fpu_ctrl_if.datapath   ctrl,
    output fpu_pkg::mant_t sum,
    output logic           sign_r
);
    import fpu_pkg::*;

    alu_state_e  state;
    logic [4:0]  step_q;
    mant_t       add_q;
    logic [23:0] mcand_q;
    logic [23:0] mplier_q;
    logic [47:0] prod_q;
    logic        sign_big;
    logic        sign_small;

    assign sign_big   = ctrl.swap ? sign_b : sign_a;
    assign sign_small = ctrl.swap ? sign_a : sign_b;

    // product point sits between bits 46 and 45, lined up with the hidden bit
    assign sum = (op_sel == op_mul) ? {1'b0, prod_q[47:20]} : add_q;

    assign ctrl.alu_done = (state == alu_done);
    assign ctrl.alu_top  = sum[28:26];

    always_ff @(posedge clk) begin
        if (reset) begin
            state  <= alu_idle;
            step_q <= 5'd0;
        end else begin
            case (state)
                alu_idle: begin
                    if (ctrl.alu_start) begin
                        state <= alu_setup;
                    end
                end
                alu_setup: begin
                    step_q <= 5'd0;
                    state  <= (op_sel == op_mul) ? alu_mul : alu_add;
                end
                alu_add: begin
                    state <= alu_done;
                end
                alu_mul: begin
                    step_q <= step_q + 5'd1;
                    if (step_q == MUL_STEPS - 5'd1) begin
                        state <= alu_done;
                    end
                end
                default: begin
                    state <= alu_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            alu_setup: begin
                mcand_q  <= big_mant[26:3];
                mplier_q <= small_mant[26:3];
                prod_q   <= 48'd0;
                sign_r   <= sign_a ^ sign_b;   // product sign, add overwrites it
            end
            alu_add: begin
                if (sign_a == sign_b) begin
                    add_q  <= big_mant + small_mant;
                    sign_r <= sign_big;
                end else if (big_mant >= small_mant) begin
                    add_q  <= big_mant - small_mant;
                    sign_r <= sign_big;
                end else begin
                    add_q  <= small_mant - big_mant;
                    sign_r <= sign_small;
                end
            end
            alu_mul: begin
                if (mplier_q[step_q]) begin
                    prod_q <= prod_q + ({24'd0, mcand_q} << step_q);
                end
            end
            default: begin
            end
        endcase
    end

endmodule

// ==== hw/fpu_normalize_round.sv ====
`timescale 1ns/1ns

module fpu_normalize_round (
    input  logic           clk,
    input  logic           reset,
    input  fpu_pkg::mant_t sum,
    input  fpu_pkg::exp_t  base_exp,
    input  logic           sign_r,
    fpu_ctrl_if.datapath   ctrl,
    output fpu_pkg::word_t r
);
    import fpu_pkg::*;

    mant_t                       loop_mant;
    exp_t                        loop_exp;
    mant_t                       src_mant;
    exp_t                        src_exp;
    mant_t                       shift_mant;
    exp_t                        shift_exp;
    logic [GUARD_BITS-1:0]       guard;
    logic [28-GUARD_BITS:0]      kept;
    logic                        round_up;
    mant_t                       rounded;
    exp_t                        exp_biased;
    frac_t                       frac_out;

    always_comb begin
        src_mant = ctrl.first_pass ? sum : loop_mant;
        src_exp  = ctrl.first_pass ? base_exp : loop_exp;
        case (ctrl.norm_cmd)
            norm_right: begin
                shift_mant = src_mant >> 1;
                shift_exp  = src_exp + 8'd1;
            end
            norm_left: begin
                shift_mant = src_mant << 1;
                shift_exp  = src_exp - 8'd1;
            end
            default: begin
                shift_mant = src_mant;
                shift_exp  = src_exp;
            end
        endcase
    end

    // nearest even on the guard bits
    assign guard    = shift_mant[GUARD_BITS-1:0];
    assign kept     = shift_mant[28:GUARD_BITS];
    assign round_up = guard[GUARD_BITS-1] && ((guard[GUARD_BITS-2:0] != '0) || kept[0]);
    assign rounded  = {kept + {{(28 - GUARD_BITS){1'b0}}, round_up}, {GUARD_BITS{1'b0}}};

    always_ff @(posedge clk) begin
        if (reset) begin
            loop_mant <= '0;
            loop_exp  <= '0;
        end else if (ctrl.norm_en) begin
            loop_mant <= rounded;   // a carry here triggers one more right pass
            loop_exp  <= shift_exp;
        end
    end

    assign ctrl.loop_top  = loop_mant[28:26];
    assign ctrl.loop_zero = (loop_mant == '0);

    // the only place the bias goes back on
    assign exp_biased = loop_exp + EXP_BIAS;
    assign frac_out   = loop_mant[25:GUARD_BITS];
    assign r          = {sign_r, exp_biased, frac_out};

endmodule

// ==== hw/fpu_operand_align.sv ====
`timescale 1ns/1ns

module fpu_operand_align (
    input  logic           clk,
    input  logic           reset,
    input  fpu_pkg::word_t a,
    input  fpu_pkg::word_t b,
    input  logic [1:0]     op,
    fpu_ctrl_if.datapath   ctrl,
    output fpu_pkg::mant_t big_mant,
    output fpu_pkg::mant_t small_mant,
    output fpu_pkg::exp_t  base_exp,
    output logic           sign_a,
    output logic           sign_b,
    output fpu_pkg::op_e   op_sel
);
    import fpu_pkg::*;

    word_t      a_q;
    word_t      b_q;
    exp_t       exp_a;
    exp_t       exp_b;
    exp_t       exp_diff;
    exp_t       exp_sum;
    frac_t      frac_a;
    frac_t      frac_b;
    mant_t      mant_a;
    mant_t      mant_b;
    logic [7:0] shift_amt;

    always_ff @(posedge clk) begin
        if (reset) begin
            op_sel <= op_add;
        end else if (ctrl.load) begin
            op_sel <= op[1] ? op_mul : op_add;
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.load) begin
            a_q <= a;
            b_q <= b;
        end
    end

    // field unpacking
    assign sign_a = a_q[31];
    assign sign_b = b_q[31];
    assign exp_a  = a_q[30:23] - EXP_BIAS;
    assign exp_b  = b_q[30:23] - EXP_BIAS;
    assign frac_a = a_q[22:0];
    assign frac_b = b_q[22:0];
    assign mant_a = {2'b00, 1'b1, frac_a, {GUARD_BITS{1'b0}}};
    assign mant_b = {2'b00, 1'b1, frac_b, {GUARD_BITS{1'b0}}};

    assign exp_diff  = exp_a - exp_b;
    assign exp_sum   = exp_a + exp_b;
    assign shift_amt = exp_diff[7] ? (8'd0 - exp_diff) : exp_diff;   // |a - b|

    assign ctrl.exp_neg  = exp_diff[7];
    assign ctrl.exp_zero = (exp_diff == 8'd0);
    assign ctrl.mag_lt   = (frac_b > frac_a);

    assign big_mant = ctrl.swap ? mant_b : mant_a;

    always_comb begin
        if (op_sel == op_mul) begin
            small_mant = ctrl.swap ? mant_a : mant_b;   // product needs no alignment
            base_exp   = exp_sum;
        end else begin
            small_mant = (ctrl.swap ? mant_a : mant_b) >> shift_amt;   // bits shifted out are lost
            base_exp   = ctrl.swap ? exp_b : exp_a;
        end
    end

endmodule

// ==== hw/fpu_pkg.sv ====
package fpu_pkg;

    // packed IEEE-754 single precision word
    typedef logic [31:0] word_t;

    // unbiased exponent, two's complement
    typedef logic [7:0] exp_t;

    // stored fraction field
    typedef logic [22:0] frac_t;

    // working mantissa {ovf[1:0], hidden, fraction[22:0], guard[2:0]}
    typedef logic [28:0] mant_t;

    typedef enum logic {
        op_add,
        op_mul
    } op_e;

    typedef enum logic [3:0] {
        idle,
        capture,
        exp_calc,
        align,
        arith,
        norm_decide,
        norm_step,
        round,
        finish
    } seq_state_e;

    typedef enum logic [2:0] {
        alu_idle,
        alu_setup,
        alu_add,
        alu_mul,
        alu_done
    } alu_state_e;

    typedef enum logic [1:0] {
        norm_hold,
        norm_right,
        norm_left
    } norm_e;

    localparam logic [7:0] EXP_BIAS   = 8'd127;
    localparam int         GUARD_BITS = 3;
    localparam logic [4:0] MUL_STEPS  = 5'd24;   // one step per multiplier bit

endpackage

// ==== hw/fpu_sequencer.sv ====
`timescale 1ns/1ns

module fpu_sequencer (
    input  logic          clk,
    input  logic          reset,
    input  logic          start,
    fpu_ctrl_if.sequencer ctrl,
    output logic          done
);
    import fpu_pkg::*;

    seq_state_e state;
    logic [2:0] top_bits;   // mantissa top bits the next pass works on

    assign top_bits = ctrl.first_pass ? ctrl.alu_top : ctrl.loop_top;

    // strobes decoded straight from the state
    assign ctrl.load      = (state == capture);
    assign ctrl.alu_start = (state == align);   // alu enters setup with swap settled
    assign ctrl.norm_en   = (state == norm_step);
    assign done           = (state == finish);

    always_ff @(posedge clk) begin
        if (reset) begin
            state           <= idle;
            ctrl.swap       <= 1'b0;
            ctrl.first_pass <= 1'b0;
            ctrl.norm_cmd   <= norm_hold;
        end else begin
            case (state)
                idle: begin
                    if (start) begin
                        state <= capture;
                    end
                end
                capture: begin
                    state <= exp_calc;
                end
                exp_calc: begin
                    state <= align;   // exponent flags settle from the operand registers
                end
                align: begin
                    // equal exponents fall back to the fraction compare
                    if (ctrl.exp_zero) begin
                        ctrl.swap <= ctrl.mag_lt;
                    end else begin
                        ctrl.swap <= ctrl.exp_neg;
                    end
                    state <= arith;
                end
                arith: begin
                    if (ctrl.alu_done) begin
                        ctrl.first_pass <= 1'b1;
                        state           <= norm_decide;
                    end
                end
                norm_decide: begin
                    if (top_bits[2:1] != 2'b00) begin
                        ctrl.norm_cmd <= norm_right;   // carry out of the hidden bit
                    end else if (!top_bits[0]) begin
                        ctrl.norm_cmd <= norm_left;
                    end else begin
                        ctrl.norm_cmd <= norm_hold;    // still needs the rounding pass
                    end
                    state <= norm_step;
                end
                norm_step: begin
                    ctrl.first_pass <= 1'b0;
                    state           <= round;
                end
                round: begin
                    if (ctrl.loop_top == 3'b001 || ctrl.loop_zero) begin
                        state <= finish;
                    end else begin
                        state <= norm_decide;   // rounding carry or more shifting
                    end
                end
                finish: begin
                    if (!start) begin
                        state <= idle;
                    end
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

endmodule

// ==== hw/fpu_top.sv ====
`timescale 1ns/1ns

module fpu_top (
    input  logic          clk,
    input  logic          reset,
    input  logic          start,
    input  logic [1:0]    op,      // bit 1 selects multiply
    input  fpu_pkg::word_t a,
    input  fpu_pkg::word_t b,
    output fpu_pkg::word_t r,
    output logic          done
);
    import fpu_pkg::*;

    mant_t big_mant;
    mant_t small_mant;
    mant_t sum;
    exp_t  base_exp;
    logic  sign_a;
    logic  sign_b;
    logic  sign_r;
    op_e   op_sel;

    fpu_ctrl_if ctrl ();

    fpu_sequencer u_sequencer (
        .clk   (clk),
        .reset (reset),
        .start (start),
        .ctrl  (ctrl.sequencer),
        .done  (done)
    );

    fpu_operand_align u_align (
        .clk        (clk),
        .reset      (reset),
        .a          (a),
        .b          (b),
        .op         (op),
        .ctrl       (ctrl.datapath),
        .big_mant   (big_mant),
        .small_mant (small_mant),
        .base_exp   (base_exp),
        .sign_a     (sign_a),
        .sign_b     (sign_b),
        .op_sel     (op_sel)
    );

    fpu_mantissa_alu u_alu (
        .clk        (clk),
        .reset      (reset),
        .big_mant   (big_mant),
        .small_mant (small_mant),
        .sign_a     (sign_a),
        .sign_b     (sign_b),
        .op_sel     (op_sel),
        .ctrl       (ctrl.datapath),
        .sum        (sum),
        .sign_r     (sign_r)
    );

    fpu_normalize_round u_norm (
        .clk      (clk),
        .reset    (reset),
        .sum      (sum),
        .base_exp (base_exp),
        .sign_r   (sign_r),
        .ctrl     (ctrl.datapath),
        .r        (r)
    );

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with Verilator, run it, and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --timing --top-module fpu_tb -f fpu.f -o fpu_sim || exit 1
out=$(./obj_dir/fpu_sim)
echo "$out"
echo "$out" | grep -qx "=== PASS ===" && echo "result: pass" || { echo "result: fail"; exit 1; }

// ==== verification/fpu_sva.sv ====
`timescale 1ns/1ns

module fpu_sva (
    input logic           clk,
    input logic           reset,
    input logic           start,
    input logic           done,
    input fpu_pkg::word_t r
);
    int   fail_count = 0;
    logic armed;   // start seen since the last result

    always_ff @(posedge clk) begin
        if (reset) begin
            armed <= 1'b0;
        end else if (done) begin
            armed <= 1'b0;
        end else if (start) begin
            armed <= 1'b1;
        end
    end

    a_reset_done: assert property (@(posedge clk) reset |=> !done)
        else begin
            fail_count++;
            $error("done is high in the cycle after reset");
        end

    // back-pressure keeps the result on the port
    a_hold_result: assert property (@(posedge clk) disable iff (reset)
        done && start |=> done && $stable(r))
        else begin
            fail_count++;
            $error("done or r changed while start was held high");
        end

    a_release: assert property (@(posedge clk) disable iff (reset)
        done && !start |=> !done)
        else begin
            fail_count++;
            $error("done did not fall after start went low");
        end

    a_no_spurious_done: assert property (@(posedge clk) disable iff (reset)
        $rose(done) |-> armed)
        else begin
            fail_count++;
            $error("done rose without a start");
        end

    // only normal results are expected here
    a_normal_result: assert property (@(posedge clk) disable iff (reset)
        done |-> (r[30:23] != 8'h00) && (r[30:23] != 8'hff))
        else begin
            fail_count++;
            $error("result exponent field is all zeros or all ones");
        end

endmodule

// ==== verification/fpu_tb.sv ====
`timescale 1ns/1ns

module fpu_tb;
    import fpu_pkg::*;

    localparam int NUM_OPS       = 12;
    localparam int CYCLES_PER_OP = 200;
    localparam int MAX_CYCLES    = NUM_OPS * CYCLES_PER_OP;

    logic       clk;
    logic       reset;
    logic       start;
    logic [1:0] op;        // bit 1 selects multiply
    word_t      a;
    word_t      b;
    word_t      r;
    logic       done;

    word_t expected_r;
    int    seed;
    int    errors;
    int    cycle_count = 0;

    fpu_top dut (
        .clk   (clk),
        .reset (reset),
        .start (start),
        .op    (op),
        .a     (a),
        .b     (b),
        .r     (r),
        .done  (done)
    );

    bind fpu_top fpu_sva u_sva (
        .clk   (clk),
        .reset (reset),
        .start (start),
        .done  (done),
        .r     (r)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("=== FAIL ===");
            $finish;
        end
    end

    // rounds an exact integer to nearest even at 24 significant bits and packs it
    function automatic word_t round_and_pack(input longint value);
        longint mag;
        longint kept;
        longint rem;
        longint half;
        int     msb;
        int     sh;
        logic   sign;
        begin
            sign = (value < 0);
            mag  = sign ? -value : value;
            msb  = 0;
            for (int i = 0; i < 62; i++) begin
                if (((mag >> i) & 64'sd1) != 0) begin
                    msb = i;
                end
            end
            if (msb > 23) begin
                sh   = msb - 23;
                kept = mag >> sh;
                rem  = mag & ((64'sd1 << sh) - 64'sd1);
                half = 64'sd1 << (sh - 1);
                if (rem > half || (rem == half && kept[0])) begin
                    kept = kept + 64'sd1;
                end
                if (kept == (64'sd1 << 24)) begin   // carry into a new leading bit
                    kept = kept >> 1;
                    msb  = msb + 1;
                end
            end else begin
                kept = mag << (23 - msb);
            end
            return {sign, 8'(msb + 127), kept[22:0]};
        end
    endfunction

    task automatic run_op(input int x, input int y, input bit mul, input int hold);
        longint exact;
        begin
            exact      = mul ? longint'(x) * longint'(y) : longint'(x) + longint'(y);
            expected_r = round_and_pack(exact);
            @(posedge clk);
            #1;
            a     = round_and_pack(longint'(x));
            b     = round_and_pack(longint'(y));
            op    = mul ? 2'b10 : 2'b00;
            start = 1'b1;
            @(posedge clk);
            #1;
            while (!done) begin
                @(posedge clk);
                #1;
            end
            assert (r == expected_r) else begin
                errors++;
                $display("FAIL r: got %h expected %h (%0d %s %0d)",
                         r, expected_r, x, mul ? "*" : "+", y);
            end
            repeat (hold) begin   // result must wait while start stays high
                @(posedge clk);
                #1;
            end
            start = 1'b0;
            while (done) begin
                @(posedge clk);
                #1;
            end
        end
    endtask

    initial begin
        int x;
        int y;
        seed   = 80;
        errors = 0;
        reset  = 1'b1;
        start  = 1'b0;
        op     = 2'b00;
        a      = '0;
        b      = '0;
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;
        repeat (4) @(posedge clk);   // idle with start low

        run_op(3, 5, 1'b0, 0);
        run_op(-12, -20, 1'b0, 2);
        run_op(1025, -1024, 1'b0, 1);   // ten left passes
        run_op(-100, 37, 1'b0, 0);
        run_op(6, -7, 1'b1, 3);
        run_op(16777216, 3, 1'b0, 1);   // guard tie with odd lsb rounds up to even
        run_op(16777216, 1, 1'b0, 0);   // guard tie with even lsb stays

        for (int i = 0; i < 5; i++) begin
            x = {$random(seed)} % 4095 + 1;
            y = {$random(seed)} % 4095 + 1;
            if ($random(seed) % 2 != 0) begin
                x = -x;
            end
            if ($random(seed) % 2 != 0) begin
                y = -y;
            end
            if (i % 2 == 1 && x + y == 0) begin
                y = 2 * y;   // zero results are out of range
            end
            run_op(x, y, (i % 2 == 0), i % 3);
        end

        repeat (4) @(posedge clk);
        $display("errors: checks %0d, assertions %0d", errors, dut.u_sva.fail_count);
        if (errors == 0 && dut.u_sva.fail_count == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule
